/* Makefile */
# Verilator flow for the event router: lint, simulate, clean

TOP := event_router_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

# build, run, then search the log for the fail message
sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" $(LOG); then \
	  echo "simulation reported a failure"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* hw/channel_fifo.sv */
// circular fifo between two valid/ack channels, with a stall input that holds the output side
`timescale 1ns/1ps

module channel_fifo #(
  parameter type item_t = logic,
  parameter int  DEPTH  = 8
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  stall,
  input  logic  in_v,
  input  item_t in_d,
  output logic  in_a,
  output logic  out_v,
  output item_t out_d,
  input  logic  out_a
);

  localparam int ADDR_W = $clog2(DEPTH);

  item_t             mem [DEPTH];
  logic [ADDR_W-1:0] head;
  logic [ADDR_W-1:0] tail;
  logic [ADDR_W-1:0] head_p1;
  logic [ADDR_W-1:0] tail_p1;
  logic              empty;
  logic              full;
  logic              push;
  logic              pop;

  ////////////////////////////////////////
  // pointers and status
  ////////////////////////////////////////

  // head is the next slot to read, tail the next slot to write
  // pointers wrap on their own since DEPTH is a power of two
  assign head_p1 = head + 1'b1;
  assign tail_p1 = tail + 1'b1;

  // one slot kept free so full and empty never look alike
  assign empty = (head == tail);
  assign full  = (tail_p1 == head);

  // transfers on each side
  assign push = in_v & in_a;
  assign pop  = out_v & out_a;

  // write side
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tail <= '0;
    end else if (push) begin
      tail <= tail_p1;
    end
  end

  // read side, only moves when not stalled
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      head <= '0;
    end else if (pop) begin
      head <= head_p1;
    end
  end

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      mem[tail] <= in_d;
    end
  end

  // input ready whenever a slot is free
  assign in_a = ~full;

  // stall hides the head entry from the consumer
  assign out_v = ~empty & ~stall;
  assign out_d = mem[head];

endmodule

/* hw/channel_merge.sv */
// combines two valid/ack channels into one, alternating between inputs when both wait
`timescale 1ns/1ps

module channel_merge #(
  parameter type item_t = logic
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  in0_v,
  input  item_t in0_d,
  output logic  in0_a,
  input  logic  in1_v,
  input  item_t in1_d,
  output logic  in1_a,
  output logic  out_v,
  output item_t out_d,
  input  logic  out_a
);

  logic sel;
  logic last_sel;

  ////////////////////////////////////////
  // arbitration state
  ////////////////////////////////////////

  // remembers which input got the last transfer
  // starts at 1 so input 0 goes first after reset
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      last_sel <= 1'b1;
    end else if (out_v && out_a) begin
      last_sel <= sel;
    end
  end

  ////////////////////////////////////////
  // input select
  ////////////////////////////////////////

  // lone valid input wins outright
  // under contention serve the one skipped last time
  always_comb begin
    if (in0_v && !in1_v) begin
      sel = 1'b0;
    end else if (!in0_v && in1_v) begin
      sel = 1'b1;
    end else if (in0_v && in1_v) begin
      sel = ~last_sel;
    end else begin
      sel = last_sel;
    end
  end

  // output channel follows the selected input
  assign out_v = in0_v | in1_v;
  assign out_d = sel ? in1_d : in0_d;

  // ack goes back to the selected side only
  assign in0_a = ~sel & out_a;
  assign in1_a = sel & out_a;

endmodule

/* hw/channel_split.sv */
// steers each event to one of two output channels by a mask and code on its value field
`timescale 1ns/1ps
`include "event_router_config.svh"

module channel_split #(
  parameter type                     item_t = event_router_pkg::event_t,
  parameter logic [`EVR_VALUE_W-1:0] MASK   = `EVR_SPLIT_MASK,
  parameter logic [`EVR_VALUE_W-1:0] CODE   = `EVR_SPLIT_CODE
) (
  input  logic  in_v,
  input  item_t in_d,
  output logic  in_a,
  output logic  out0_v,
  output item_t out0_d,
  input  logic  out0_a,
  output logic  out1_v,
  output item_t out1_d,
  input  logic  out1_a
);

  logic sel0;

  // masked value equal to the code goes to out0
  // anything else falls through to out1
  assign sel0 = ((in_d.value & MASK) == CODE);

  ////////////////////////////////////////
  // output channels
  ////////////////////////////////////////

  // only the chosen side sees valid
  assign out0_v = in_v & sel0;
  assign out1_v = in_v & ~sel0;

  // data fans out to both, valid tells which one counts
  assign out0_d = in_d;
  assign out1_d = in_d;

  // ack comes from the chosen side only
  assign in_a = sel0 ? out0_a : out1_a;

endmodule

/* hw/event_router_pkg.sv */
// shared event types for the router; referenced by scoped name from the rtl and the testbench
`include "event_router_config.svh"

package event_router_pkg;

  ////////////////////////////////////////
  // source identification
  ////////////////////////////////////////

  // number of the source that produced an event
  typedef logic [`EVR_TAG_W-1:0] source_tag_t;

  ////////////////////////////////////////
  // channel payload
  ////////////////////////////////////////

  // one event as it travels on every channel
  // tag sits in the upper bits, value in the lower bits
  typedef struct packed {
    source_tag_t             tag;
    logic [`EVR_VALUE_W-1:0] value;
  } event_t;

  // total payload width, handy for checks and displays
  localparam int EVENT_W = $bits(event_t);

endpackage

/* hw/event_router_top.sv */
// event router top: two pulse sources, fair merge, fifo queue and priority/bulk split
`timescale 1ns/1ps
`include "event_router_config.svh"

module event_router_top (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     pulse0,
  input  logic [`EVR_VALUE_W-1:0]  value0,
  input  logic                     pulse1,
  input  logic [`EVR_VALUE_W-1:0]  value1,
  input  logic                     stall,
  output logic                     busy0,
  output logic                     busy1,
  output logic                     pri_v,
  output event_router_pkg::event_t pri_d,
  input  logic                     pri_a,
  output logic                     bulk_v,
  output event_router_pkg::event_t bulk_d,
  input  logic                     bulk_a
);

  // source channels
  logic                     s0_v, s0_a;
  event_router_pkg::event_t s0_d;
  logic                     s1_v, s1_a;
  event_router_pkg::event_t s1_d;
  // merged stream into the fifo
  logic                     m_v, m_a;
  event_router_pkg::event_t m_d;
  // fifo output into the split
  logic                     q_v, q_a;
  event_router_pkg::event_t q_d;

  ////////////////////////////////////////
  // sources
  ////////////////////////////////////////

  pulse_to_channel #(.SOURCE_TAG(event_router_pkg::source_tag_t'(0))) i_src0 (
    .clk(clk), .reset(reset), .pulse(pulse0), .value(value0), .busy(busy0),
    .out_v(s0_v), .out_d(s0_d), .out_a(s0_a)
  );

  pulse_to_channel #(.SOURCE_TAG(event_router_pkg::source_tag_t'(1))) i_src1 (
    .clk(clk), .reset(reset), .pulse(pulse1), .value(value1), .busy(busy1),
    .out_v(s1_v), .out_d(s1_d), .out_a(s1_a)
  );

  ////////////////////////////////////////
  // merge, queue, split
  ////////////////////////////////////////

  channel_merge #(.item_t(event_router_pkg::event_t)) i_merge (
    .clk(clk), .reset(reset),
    .in0_v(s0_v), .in0_d(s0_d), .in0_a(s0_a),
    .in1_v(s1_v), .in1_d(s1_d), .in1_a(s1_a),
    .out_v(m_v), .out_d(m_d), .out_a(m_a)
  );

  // stall holds the queue head back from the split
  channel_fifo #(.item_t(event_router_pkg::event_t), .DEPTH(`EVR_FIFO_DEPTH)) i_fifo (
    .clk(clk), .reset(reset), .stall(stall),
    .in_v(m_v), .in_d(m_d), .in_a(m_a),
    .out_v(q_v), .out_d(q_d), .out_a(q_a)
  );

  // priority events on out0, bulk on out1
  channel_split #(
    .item_t(event_router_pkg::event_t), .MASK(`EVR_SPLIT_MASK), .CODE(`EVR_SPLIT_CODE)
  ) i_split (
    .in_v(q_v), .in_d(q_d), .in_a(q_a),
    .out0_v(pri_v), .out0_d(pri_d), .out0_a(pri_a),
    .out1_v(bulk_v), .out1_d(bulk_d), .out1_a(bulk_a)
  );

endmodule

/* hw/pulse_to_channel.sv */
// turns a sparse pulse with a value into a tagged valid/ack channel, one event at a time
`timescale 1ns/1ps
`include "event_router_config.svh"

module pulse_to_channel #(
  parameter event_router_pkg::source_tag_t SOURCE_TAG = '0
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          pulse,
  input  logic [`EVR_VALUE_W-1:0]       value,
  output logic                          busy,
  output logic                          out_v,
  output event_router_pkg::event_t      out_d,
  input  logic                          out_a
);

  typedef enum logic {
    IDLE,
    SENDING
  } state_t;

  state_t                  state;
  logic [`EVR_VALUE_W-1:0] value_q;

  // idle waits for a pulse, sending waits for the ack
  // a pulse while sending is dropped on purpose
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (pulse) state <= SENDING;
        SENDING: if (out_a) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // capture the value with the pulse
  // held steady for the whole sending phase
  always_ff @(posedge clk) begin
    if (state == IDLE && pulse) begin
      value_q <= value;
    end
  end

  // channel side
  assign out_v       = (state == SENDING);
  assign out_d.tag   = SOURCE_TAG;
  assign out_d.value = value_q;

  // producer can see that a new pulse would be lost
  assign busy = (state == SENDING);

endmodule

/* include/event_router_config.svh */
// build-time constants for the event router, included by every file that sizes or routes events
`ifndef EVENT_ROUTER_CONFIG_SVH
`define EVENT_ROUTER_CONFIG_SVH

////////////////////////////////////////
// event payload widths
////////////////////////////////////////

// width of the value carried by each event
`define EVR_VALUE_W 12

// width of the source tag attached at each source
`define EVR_TAG_W 4

////////////////////////////////////////
// queueing and routing
////////////////////////////////////////

// fifo slots, power of two; one slot always stays empty
`define EVR_FIFO_DEPTH 8

// value bits looked at by the split
`define EVR_SPLIT_MASK 12'hF00
// pattern under the mask that marks a priority event
`define EVR_SPLIT_CODE 12'hA00

`endif

/* sources.f */
+incdir+include
hw/event_router_pkg.sv
hw/pulse_to_channel.sv
hw/channel_merge.sv
hw/channel_fifo.sv
hw/channel_split.sv
hw/event_router_top.sv
tb/event_router_properties.sv
tb/event_router_tb.sv

/* tb/event_router_properties.sv */
// handshake assertions for the event router, attached to the top level by a bind in the testbench
`timescale 1ns/1ps

module event_router_properties (
  input logic                     clk,
  input logic                     reset,
  input logic                     busy0,
  input logic                     busy1,
  input logic                     s0_v,
  input logic                     s0_a,
  input event_router_pkg::event_t s0_d,
  input logic                     s1_v,
  input logic                     s1_a,
  input event_router_pkg::event_t s1_d,
  input logic                     pri_v,
  input logic                     pri_a,
  input event_router_pkg::event_t pri_d,
  input logic                     bulk_v,
  input logic                     bulk_a,
  input event_router_pkg::event_t bulk_d
);

  ////////////////////////////////////////
  // senders hold valid and data until ack
  ////////////////////////////////////////

  s0_hold: assert property (@(posedge clk) disable iff (reset)
    s0_v && !s0_a |=> s0_v && $stable(s0_d))
    else $error("source 0 channel dropped valid or changed data before its ack");

  s1_hold: assert property (@(posedge clk) disable iff (reset)
    s1_v && !s1_a |=> s1_v && $stable(s1_d))
    else $error("source 1 channel dropped valid or changed data before its ack");

  pri_hold: assert property (@(posedge clk) disable iff (reset)
    pri_v && !pri_a |=> pri_v && $stable(pri_d))
    else $error("priority output dropped valid or changed data before its ack");

  bulk_hold: assert property (@(posedge clk) disable iff (reset)
    bulk_v && !bulk_a |=> bulk_v && $stable(bulk_d))
    else $error("bulk output dropped valid or changed data before its ack");

  ////////////////////////////////////////
  // reset and busy
  ////////////////////////////////////////

  // nothing offered while reset is held
  quiet_in_reset: assert property (@(posedge clk)
    reset |-> !pri_v && !bulk_v && !busy0 && !busy1)
    else $error("valid or busy seen during reset");

  // a busy source always offers its event
  busy0_valid: assert property (@(posedge clk) disable iff (reset) busy0 |-> s0_v)
    else $error("source 0 busy without a valid channel");

  busy1_valid: assert property (@(posedge clk) disable iff (reset) busy1 |-> s1_v)
    else $error("source 1 busy without a valid channel");

endmodule

/* tb/event_router_tb.sv */
// self-checking testbench that runs as the simulation top of the event router
`timescale 1ns/1ps
`include "event_router_config.svh"

module event_router_tb;

  // one scoreboard entry per accepted pulse
  typedef struct packed {
    event_router_pkg::event_t ev;
    logic                     pri;
    int                       accept_cycle;
  } expect_t;

  logic                     clk = 1'b0;
  logic                     reset;
  logic                     pulse0;
  logic [`EVR_VALUE_W-1:0]  value0;
  logic                     pulse1;
  logic [`EVR_VALUE_W-1:0]  value1;
  logic                     stall;
  logic                     busy0;
  logic                     busy1;
  logic                     pri_v;
  event_router_pkg::event_t pri_d;
  logic                     pri_a;
  logic                     bulk_v;
  event_router_pkg::event_t bulk_d;
  logic                     bulk_a;

  expect_t     pending[$];
  logic [31:0] lcg_state = 32'd30;
  string       test_name = "reset";
  int          cycle = 0;
  int          checks = 0;
  int          errors = 0;
  int          err_mark = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          accepted = 0;
  int          arrivals = 0;
  int          pri_seen = 0;
  int          bulk_seen = 0;
  int          contended = 0;
  logic        check_latency = 1'b0;
  logic        last_served = 1'b1;
  // negedge samples that the stimulus reads at the next rising edge
  logic        busy0_s = 1'b0;
  logic        busy1_s = 1'b0;
  logic        out_v_s = 1'b0;
  logic        pri_wait_p = 1'b0;
  logic        bulk_wait_p = 1'b0;
  event_router_pkg::event_t pri_d_p;
  event_router_pkg::event_t bulk_d_p;

  event_router_top i_dut (.*);

  bind event_router_top event_router_properties i_props (
    .clk(clk), .reset(reset), .busy0(busy0), .busy1(busy1),
    .s0_v(s0_v), .s0_a(s0_a), .s0_d(s0_d), .s1_v(s1_v), .s1_a(s1_a), .s1_d(s1_d),
    .pri_v(pri_v), .pri_a(pri_a), .pri_d(pri_d),
    .bulk_v(bulk_v), .bulk_a(bulk_a), .bulk_d(bulk_d)
  );

  always #50 clk = ~clk;

  // edge count for the latency check
  always @(posedge clk) cycle <= cycle + 1;

  ////////////////////////////////////////
  // random numbers and reference model
  ////////////////////////////////////////

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // about half the values are forced onto the priority code
  function automatic logic [`EVR_VALUE_W-1:0] random_value();
    logic [31:0] r;
    r = next_random();
    if (r[31]) return `EVR_SPLIT_CODE | (r[`EVR_VALUE_W+15:16] & ~`EVR_SPLIT_MASK);
    return r[`EVR_VALUE_W+15:16];
  endfunction

  // 1 means priority output, 0 means bulk
  function automatic logic expected_route(input event_router_pkg::event_t ev);
    return (ev.value & `EVR_SPLIT_MASK) == `EVR_SPLIT_CODE;
  endfunction

  ////////////////////////////////////////
  // scoreboard
  ////////////////////////////////////////

  task automatic record_accept(input int src, input logic [`EVR_VALUE_W-1:0] value);
    expect_t e;
    e.ev.tag = event_router_pkg::source_tag_t'(src);
    e.ev.value = value;
    e.pri = expected_route(e.ev);
    e.accept_cycle = cycle;
    pending.push_back(e);
    accepted++;
  endtask

  // oldest entry with the same output and source is the one due next
  task automatic check_output(input logic to_pri, input event_router_pkg::event_t got);
    int      idx;
    expect_t e;
    idx = -1;
    arrivals++;
    if (to_pri) pri_seen++;
    else bulk_seen++;
    foreach (pending[i]) begin
      if (idx < 0 && pending[i].pri == to_pri && pending[i].ev.tag == got.tag) idx = i;
    end
    checks++;
    assert (idx >= 0) else begin
      $display("%s: event %h on %s output was never accepted for it", test_name, got,
               to_pri ? "pri" : "bulk");
      errors++;
    end
    if (idx >= 0) begin
      e = pending[idx];
      pending.delete(idx);
      checks += 2;
      assert (got == e.ev) else begin
        $display("FAILED %s: expected %h, actual %h", test_name, e.ev, got);
        errors++;
      end
      assert (expected_route(got) == to_pri) else begin
        $display("FAILED %s: expected route %0d, actual route %0d", test_name,
                 expected_route(got), to_pri);
        errors++;
      end
      if (check_latency) begin
        checks++;
        assert (cycle - e.accept_cycle == 2) else begin
          $display("FAILED %s: expected latency 2, actual latency %0d", test_name,
                   cycle - e.accept_cycle);
          errors++;
        end
      end
    end
  endtask

  // under contention the merge must serve the other source
  task automatic check_fairness();
    logic served;
    if (i_dut.m_v && i_dut.m_a) begin
      served = i_dut.s1_a;
      if (i_dut.s0_v && i_dut.s1_v) begin
        contended++;
        checks++;
        assert (served != last_served) else begin
          $display("FAILED %s: expected source %0d, actual source %0d", test_name,
                   !last_served, served);
          errors++;
        end
      end
      last_served = served;
    end
  endtask

  // a waiting output keeps valid and data
  task automatic check_hold(input string side, input logic wait_p,
                            input event_router_pkg::event_t d_p, input logic v,
                            input event_router_pkg::event_t d);
    if (wait_p) begin
      checks++;
      assert (v && d == d_p) else begin
        $display("FAILED %s: %s expected held %h, actual %h valid %0b", test_name, side,
                 d_p, d, v);
        errors++;
      end
    end
  endtask

  // comparing process samples at the falling edge where everything has settled
  always @(negedge clk) begin
    if (reset) begin
      last_served = 1'b1;
    end else begin
      if (pulse0 && !busy0) record_accept(0, value0);
      if (pulse1 && !busy1) record_accept(1, value1);
      if (pri_v && pri_a) check_output(1'b1, pri_d);
      if (bulk_v && bulk_a) check_output(1'b0, bulk_d);
      check_fairness();
      check_hold("pri", pri_wait_p, pri_d_p, pri_v, pri_d);
      check_hold("bulk", bulk_wait_p, bulk_d_p, bulk_v, bulk_d);
      if (stall) begin
        checks++;
        assert (!pri_v && !bulk_v) else begin
          $display("%s: an output raised valid while stall was high", test_name);
          errors++;
        end
      end
    end
    busy0_s = busy0;
    busy1_s = busy1;
    out_v_s = pri_v | bulk_v;
    pri_wait_p = pri_v & ~pri_a;
    bulk_wait_p = bulk_v & ~bulk_a;
    pri_d_p = pri_d;
    bulk_d_p = bulk_d;
  end

  ////////////////////////////////////////
  // stimulus, waits and reporting
  ////////////////////////////////////////

  // one clock of stimulus; a pulse only goes out to an idle source
  task automatic drive_cycle(input logic want0, input logic want1,
                             input logic [`EVR_VALUE_W-1:0] v0,
                             input logic [`EVR_VALUE_W-1:0] v1,
                             input logic st, input logic pa, input logic ba);
    @(posedge clk);
    pulse0 <= want0 && !busy0_s && !pulse0;
    pulse1 <= want1 && !busy1_s && !pulse1;
    value0 <= v0;
    value1 <= v1;
    stall <= st;
    pri_a <= pa;
    bulk_a <= ba;
  endtask

  task automatic print_summary();
    $display("summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, checks, errors);
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    print_summary();
    $display("TEST FAIL");
    $finish;
  endtask

  // until every accepted event has left and both outputs are idle
  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > limit) abort_run($sformatf("%s: timed out with %0d events still in flight",
                                         test_name, pending.size()));
    end while (pending.size() != 0 || out_v_s);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_mark = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == err_mark) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, errors - err_mark);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("%s: %s", test_name, what);
      errors++;
    end
  endtask

  task automatic check_count(input string what, input int expected, input int actual);
    checks++;
    assert (actual == expected) else begin
      $display("FAILED %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic test_single_latency();
    int mark;
    begin_test("single event latency");
    mark = accepted;
    check_latency = 1'b1;
    drive_cycle(1'b1, 1'b0, `EVR_SPLIT_CODE | 12'h05A, '0, 1'b0, 1'b1, 1'b1);
    drive_cycle(1'b0, 1'b0, '0, '0, 1'b0, 1'b1, 1'b1);
    wait_drained(20);
    drive_cycle(1'b0, 1'b1, '0, 12'h123, 1'b0, 1'b1, 1'b1);
    drive_cycle(1'b0, 1'b0, '0, '0, 1'b0, 1'b1, 1'b1);
    wait_drained(20);
    check_latency = 1'b0;
    check_count("accepted pulses", 2, accepted - mark);
    end_test();
  endtask

  // random values and occasional stall with both outputs always ready
  task automatic test_routing();
    logic [31:0] r;
    int          pri_mark;
    int          bulk_mark;
    begin_test("routing");
    pri_mark = pri_seen;
    bulk_mark = bulk_seen;
    for (int i = 0; i < 300; i++) begin
      r = next_random();
      drive_cycle(r[31], r[30], random_value(), random_value(), r[29] & r[28], 1'b1, 1'b1);
    end
    drive_cycle(1'b0, 1'b0, '0, '0, 1'b0, 1'b1, 1'b1);
    wait_drained(100);
    expect_true(pri_seen > pri_mark, "no event reached the priority output");
    expect_true(bulk_seen > bulk_mark, "no event reached the bulk output");
    end_test();
  endtask

  // both sources pulse whenever idle while the outputs ack at random
  task automatic test_order_fairness();
    logic [31:0] r;
    int          mark;
    begin_test("order and fairness");
    mark = contended;
    for (int i = 0; i < 300; i++) begin
      r = next_random();
      drive_cycle(1'b1, 1'b1, random_value(), random_value(), 1'b0, r[31] | r[30],
                  r[29] | r[28]);
    end
    drive_cycle(1'b0, 1'b0, '0, '0, 1'b0, 1'b1, 1'b1);
    wait_drained(100);
    expect_true(contended > mark, "the merge never saw both sources valid at once");
    end_test();
  endtask

  task automatic test_stall_backpressure();
    int mark;
    int arr_mark;
    begin_test("stall and back-pressure");
    mark = accepted;
    arr_mark = arrivals;
    for (int i = 0; i < 40; i++) begin
      drive_cycle(1'b1, 1'b1, random_value(), random_value(), 1'b1, 1'b1, 1'b1);
    end
    drive_cycle(1'b0, 1'b0, '0, '0, 1'b1, 1'b1, 1'b1);
    drive_cycle(1'b0, 1'b0, '0, '0, 1'b1, 1'b1, 1'b1);
    expect_true(busy0_s && busy1_s, "sources were not both busy with the fifo full");
    // full fifo keeps one slot free and each source holds one more event
    check_count("events held", `EVR_FIFO_DEPTH - 1 + 2, accepted - mark);
    drive_cycle(1'b0, 1'b0, '0, '0, 1'b0, 1'b1, 1'b1);
    wait_drained(100);
    check_count("events delivered", accepted - mark, arrivals - arr_mark);
    end_test();
  endtask

  task automatic test_ack_low();
    logic [31:0] r;
    int          arr_mark;
    begin_test("output ack held low");
    arr_mark = arrivals;
    for (int i = 0; i < 30; i++) begin
      r = next_random();
      drive_cycle(r[31], r[30], random_value(), random_value(), 1'b0, 1'b0, 1'b0);
    end
    drive_cycle(1'b0, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
    check_count("events delivered without ack", 0, arrivals - arr_mark);
    expect_true(out_v_s, "no event was waiting on an output");
    drive_cycle(1'b0, 1'b0, '0, '0, 1'b0, 1'b1, 1'b1);
    wait_drained(100);
    end_test();
  endtask

  initial begin
    reset = 1'b1;
    pulse0 = 1'b0;
    value0 = '0;
    pulse1 = 1'b0;
    value1 = '0;
    stall = 1'b0;
    pri_a = 1'b1;
    bulk_a = 1'b1;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    test_single_latency();
    test_routing();
    test_order_fairness();
    test_stall_backpressure();
    test_ack_low();
    print_summary();
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
